// ==== logic/mbox_macros.svh ====
// mailbox constants; offsets are word addresses (bits 7:2) and the depth must be a power of two, 4 or more
`ifndef MBOX_MACROS_SVH
`define MBOX_MACROS_SVH

// register group code, matched against dstaddr[19:16]
`define MBOX_EGROUP_MMR 4'hF

// word offsets within the register group, matched against addr[7:2]
`define MBOX_REG_LO 6'h09   // head bits 31:0, the mesh store target
`define MBOX_REG_HI 6'h0A   // head bits 63:32, read pops
`define MBOX_REG_STAT 6'h0B // {full, not empty}

// link id this mailbox answers to, dstaddr[31:20]
`define MBOX_LINK_ID_DEFAULT 12'h810

// fifo entries
`define MBOX_DEPTH_DEFAULT 16

`endif

// ==== logic/mbox_pkg.sv ====
// mailbox types; the mesh packet layout is fixed at 104 bits with write in bit 0
package mbox_pkg;

   // mesh packet as it arrives on the write port, msb first
   typedef struct packed
   {
      logic [31:0] srcaddr;  // becomes the high word of the entry
      logic [31:0] data;     // becomes the low word
      logic [31:0] dstaddr;  // link id, group and offset
      logic [4:0]  ctrlmode; // not used by the mailbox
      logic [1:0]  datamode; // not used by the mailbox
      logic        write;
   } emesh_packet_t;

   // one fifo entry
   typedef struct packed
   {
      logic [31:0] hi; // source address
      logic [31:0] lo; // data word
   } mbox_entry_t;

   // processor register request, valid for one cycle
   typedef struct packed
   {
      logic       en;   // access strobe
      logic       we;   // write, ignored by the mailbox
      logic [7:0] addr; // byte address, bits 7:2 select the register
   } mi_req_t;

endpackage

// ==== logic/emesh_decode.sv ====
// combinational only; store does not look at fifo state, so a full fifo must drop the push itself
`include "mbox_macros.svh"

module emesh_decode
#(
   parameter logic [11:0] link_id = `MBOX_LINK_ID_DEFAULT // this link's id
)
(
   input  mbox_pkg::emesh_packet_t packet,
   input  logic                    access,
   output logic                    store,
   output mbox_pkg::mbox_entry_t   entry
);

   logic id_hit;    // dstaddr[31:20] matches
   logic group_hit; // register group
   logic reg_hit;   // mailbox low register

   // address fields of the destination
   assign id_hit    = (packet.dstaddr[31:20] == link_id);
   assign group_hit = (packet.dstaddr[19:16] == `MBOX_EGROUP_MMR);
   assign reg_hit   = (packet.dstaddr[7:2] == `MBOX_REG_LO);

   // only a write to the low register is a mailbox store
   assign store = access & packet.write & id_hit & group_hit & reg_hit;

   // srcaddr rides along as the upper word
   assign entry.hi = packet.srcaddr;
   assign entry.lo = packet.data;

endmodule

// ==== logic/async_fifo.sv ====
// first-word-fall-through dual-clock fifo; depth a power of two and at least 4, full/empty outputs in rd_clk domain
`include "mbox_macros.svh"

module async_fifo
#(
   parameter type payload_t = logic [63:0], // stored word
   parameter int  depth     = `MBOX_DEPTH_DEFAULT
)
(
   input  logic     wr_clk,
   input  logic     rd_clk,
   input  logic     arst_n,  // resets both domains
   input  logic     push,    // wr_clk domain
   input  payload_t din,
   input  logic     pop,     // rd_clk domain
   output payload_t dout,    // head, valid while not empty
   output logic     empty,
   output logic     full     // rd_clk view of the write pointer
);

   localparam int aw = $clog2(depth); // memory address width

   payload_t mem [depth]; // storage, no reset

   // write domain
   logic [aw:0] wr_bin;      // binary write pointer, one wrap bit
   logic [aw:0] wr_bin_next;
   logic [aw:0] wr_gray;     // crosses into rd_clk
   logic [aw:0] wr_gray_next;
   logic [aw:0] rd_gray_w1;  // sync stage 1
   logic [aw:0] rd_gray_w2;  // sync stage 2
   logic        wr_full;     // drops pushes, zero latency
   logic        wr_inc;

   // read domain
   logic [aw:0] rd_bin;
   logic [aw:0] rd_bin_next;
   logic [aw:0] rd_gray;     // crosses into wr_clk
   logic [aw:0] rd_gray_next;
   logic [aw:0] wr_gray_r1;
   logic [aw:0] wr_gray_r2;
   logic        rd_inc;

   function automatic logic [aw:0] bin2gray(input logic [aw:0] b);
      return b ^ (b >> 1);
   endfunction

   // push while full is ignored here
   assign wr_inc       = push & ~wr_full;
   assign wr_bin_next  = wr_bin + {{aw{1'b0}}, wr_inc};
   assign wr_gray_next = bin2gray(wr_bin_next);

   always_ff @(posedge wr_clk)
   begin
      if (wr_inc)
      begin
         mem[wr_bin[aw-1:0]] <= din;
      end
   end

   always_ff @(posedge wr_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_bin     <= '0;
         wr_gray    <= '0;
         rd_gray_w1 <= '0;
         rd_gray_w2 <= '0;
         wr_full    <= 1'b0;
      end
      else
      begin
         wr_bin     <= wr_bin_next;
         wr_gray    <= wr_gray_next;
         rd_gray_w1 <= rd_gray;    // two-flop sync of read pointer
         rd_gray_w2 <= rd_gray_w1;
         // full when next write pointer wraps onto the read pointer
         wr_full    <= (wr_gray_next ==
                        {~rd_gray_w2[aw:aw-1], rd_gray_w2[aw-2:0]});
      end
   end

   // pop while empty is ignored here
   assign rd_inc       = pop & ~empty;
   assign rd_bin_next  = rd_bin + {{aw{1'b0}}, rd_inc};
   assign rd_gray_next = bin2gray(rd_bin_next);

   always_ff @(posedge rd_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rd_bin     <= '0;
         rd_gray    <= '0;
         wr_gray_r1 <= '0;
         wr_gray_r2 <= '0;
      end
      else
      begin
         rd_bin     <= rd_bin_next;
         rd_gray    <= rd_gray_next;
         wr_gray_r1 <= wr_gray;    // two-flop sync of write pointer
         wr_gray_r2 <= wr_gray_r1;
      end
   end

   // flags compare registered pointers only
   assign empty = (rd_gray == wr_gray_r2);
   assign full  = (wr_gray_r2 == {~rd_gray[aw:aw-1], rd_gray[aw-2:0]});

   assign dout = mem[rd_bin[aw-1:0]]; // fall-through read

endmodule

// ==== logic/mbox_regs.sv ====
// read-only register block; processor writes are ignored and any unknown offset reads the low word
`include "mbox_macros.svh"

module mbox_regs
(
   input  logic                  rd_clk,
   input  logic                  arst_n,
   input  mbox_pkg::mi_req_t     mi,
   input  mbox_pkg::mbox_entry_t head,  // fifo head, fall-through
   input  logic                  empty,
   input  logic                  full,
   input  logic                  irq_en,
   output logic                  pop,
   output logic [63:0]           mi_dout,
   output logic                  mailbox_irq
);

   logic        rd;      // read request this cycle
   logic [5:0]  reg_sel; // word offset
   logic [31:0] status;
   logic [31:0] rdata;   // low half of next mi_dout

   assign rd      = mi.en & ~mi.we;
   assign reg_sel = mi.addr[7:2];
   assign status  = {30'b0, full, ~empty};

   // reading the high word consumes the entry
   assign pop = rd & (reg_sel == `MBOX_REG_HI) & ~empty;

   always_comb
   begin
      case (reg_sel)
         `MBOX_REG_LO:   rdata = head.lo;
         `MBOX_REG_HI:   rdata = head.hi;  // value before the pop
         `MBOX_REG_STAT: rdata = status;
         default:        rdata = head.lo;
      endcase
   end

   // read data held until the next read
   always_ff @(posedge rd_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         mi_dout <= '0;
      end
      else if (rd)
      begin
         mi_dout <= {head.hi, rdata}; // upper half always head.hi
      end
   end

   // level interrupt, not empty or full
   always_ff @(posedge rd_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         mailbox_irq <= 1'b0;
      end
      else
      begin
         mailbox_irq <= irq_en & (~empty | full);
      end
   end

endmodule

// ==== logic/emailbox_top.sv ====
// mesh-to-processor mailbox; writes arriving while full are dropped and there is no back-pressure
`include "mbox_macros.svh"

module emailbox_top
#(
   parameter logic [11:0] link_id = `MBOX_LINK_ID_DEFAULT,
   parameter int          depth   = `MBOX_DEPTH_DEFAULT  // power of two
)
(
   input  logic                    wr_clk,       // mesh side
   input  logic                    rd_clk,       // processor side
   input  logic                    arst_n,
   input  logic                    emesh_access,
   input  mbox_pkg::emesh_packet_t emesh_packet,
   input  mbox_pkg::mi_req_t       mi,
   input  logic                    mailbox_irq_en,
   output logic [63:0]             mi_dout,
   output logic                    mailbox_irq
);

   import mbox_pkg::*;

   logic        store; // wr_clk domain push
   mbox_entry_t entry;
   mbox_entry_t head;  // rd_clk domain
   logic        pop;
   logic        empty;
   logic        full;

   emesh_decode #(.link_id(link_id)) u_decode
   (
      .packet (emesh_packet),
      .access (emesh_access),
      .store  (store),
      .entry  (entry)
   );

   async_fifo #(.payload_t(mbox_entry_t), .depth(depth)) u_fifo
   (
      .wr_clk (wr_clk),
      .rd_clk (rd_clk),
      .arst_n (arst_n),
      .push   (store),
      .din    (entry),
      .pop    (pop),
      .dout   (head),
      .empty  (empty),
      .full   (full)
   );

   mbox_regs u_regs
   (
      .rd_clk      (rd_clk),
      .arst_n      (arst_n),
      .mi          (mi),
      .head        (head),
      .empty       (empty),
      .full        (full),
      .irq_en      (mailbox_irq_en),
      .pop         (pop),
      .mi_dout     (mi_dout),
      .mailbox_irq (mailbox_irq)
   );

endmodule

// ==== sim/emailbox_asserts.sv ====
// checks on mbox_regs; mi_dout bits 63:32 are only known after a read of a non-empty fifo
module emailbox_asserts
(
   input logic              rd_clk,
   input logic              arst_n,
   input mbox_pkg::mi_req_t mi,
   input logic              empty,
   input logic              irq_en,
   input logic              pop,
   input logic [63:0]       mi_dout,
   input logic              mailbox_irq
);

   timeunit 1ns;
   timeprecision 100ps;

   int fail_cnt = 0; // summed into the testbench error count

   // pop only for a non-empty fifo
   assert property (@(posedge rd_clk) disable iff (!arst_n) !(pop && empty))
   else
   begin
      fail_cnt++;
      $error("pop asserted while the fifo is empty");
   end

   // irq follows the enable within one cycle
   assert property (@(posedge rd_clk) disable iff (!arst_n) !irq_en |=> !mailbox_irq)
   else
   begin
      fail_cnt++;
      $error("mailbox_irq high one cycle after irq_en was low");
   end

   assert property (@(posedge rd_clk) disable iff (!arst_n) !$isunknown(mi_dout[31:0]))
   else
   begin
      fail_cnt++;
      $error("mi_dout low word has unknown bits");
   end

   // whole word defined once a real entry was read
   assert property (@(posedge rd_clk) disable iff (!arst_n)
                    (mi.en && !mi.we && !empty) |=> !$isunknown(mi_dout))
   else
   begin
      fail_cnt++;
      $error("mi_dout has unknown bits after a read of a non-empty fifo");
   end

endmodule

// ==== sim/emailbox_tb.sv ====
// runs emailbox_top at default link id and depth; status is only compared once writes have settled
`include "mbox_macros.svh"

module emailbox_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import mbox_pkg::*;

   localparam int          depth      = `MBOX_DEPTH_DEFAULT;
   localparam logic [11:0] link_id    = `MBOX_LINK_ID_DEFAULT;
   localparam int          max_cycles = 4000; // about twice the summed test lengths

   // expected read word and its defined bits
   typedef struct packed
   {
      logic [63:0] value;
      logic [63:0] care;
   } expect_t;

   logic          wr_clk;
   logic          rd_clk;
   logic          arst_n;
   logic          emesh_access;
   emesh_packet_t emesh_packet;
   mi_req_t       mi;
   logic          mailbox_irq_en;
   logic [63:0]   mi_dout;
   logic          mailbox_irq;

   mbox_entry_t   model_q[$]; // reference fifo
   expect_t       pend;       // read awaiting compare
   logic          pend_valid;
   logic          check_rd;   // compare this request
   integer        seed;
   int            err_cnt;
   int            chk_cnt;
   int            test_cnt;
   int            test_err0;  // error count at test start
   int            cycles;

   emailbox_top #(.link_id(link_id), .depth(depth)) dut_i
   (
      .wr_clk         (wr_clk),
      .rd_clk         (rd_clk),
      .arst_n         (arst_n),
      .emesh_access   (emesh_access),
      .emesh_packet   (emesh_packet),
      .mi             (mi),
      .mailbox_irq_en (mailbox_irq_en),
      .mi_dout        (mi_dout),
      .mailbox_irq    (mailbox_irq)
   );

   bind mbox_regs emailbox_asserts asserts_i
   (
      .rd_clk      (rd_clk),
      .arst_n      (arst_n),
      .mi          (mi),
      .empty       (empty),
      .irq_en      (irq_en),
      .pop         (pop),
      .mi_dout     (mi_dout),
      .mailbox_irq (mailbox_irq)
   );

   always #20 rd_clk = ~rd_clk; // 40 ns
   always #14 wr_clk = ~wr_clk; // 28 ns, unrelated to rd_clk

   always @(posedge rd_clk)
   begin
      cycles = cycles + 1;
      if (cycles >= max_cycles)
      begin
         $display("timeout: run did not finish within %0d rd_clk cycles", max_cycles);
         $display("Testbench failed");
         $finish;
      end
   end

   function automatic logic [31:0] make_dst(input logic [11:0] id, input logic [3:0] grp,
                                            input logic [5:0] off);
      return {id, grp, 8'h00, off, 2'b00};
   endfunction

   function automatic emesh_packet_t make_pkt(input logic [31:0] dst, input logic wr);
      emesh_packet_t p;
      p.srcaddr  = $random(seed);
      p.data     = $random(seed);
      p.dstaddr  = dst;
      p.ctrlmode = $random(seed); // don't care fields
      p.datamode = $random(seed);
      p.write    = wr;
      return p;
   endfunction

   // stored only for a write to the low mailbox register of this link
   function automatic logic is_store(input emesh_packet_t p, input logic acc);
      return acc && p.write && (p.dstaddr[31:20] == link_id)
             && (p.dstaddr[19:16] == `MBOX_EGROUP_MMR) && (p.dstaddr[7:2] == `MBOX_REG_LO);
   endfunction

   function automatic void ref_write(input emesh_packet_t p, input logic acc);
      mbox_entry_t e;
      if (is_store(p, acc) && model_q.size() < depth) // full drops
      begin
         e.hi = p.srcaddr;
         e.lo = p.data;
         model_q.push_back(e);
      end
   endfunction

   // expected mi_dout for a read; a high read pops the model
   function automatic expect_t ref_read(input logic [7:0] addr);
      expect_t     r;
      mbox_entry_t h;
      logic        ne;
      ne     = (model_q.size() > 0);
      h      = ne ? model_q[0] : '0;
      r.care = ne ? '1 : '0; // stale memory behind an empty head
      case (addr[7:2])
         `MBOX_REG_HI:
         begin
            r.value = {h.hi, h.hi};
            if (ne)
            begin
               void'(model_q.pop_front());
            end
         end
         `MBOX_REG_STAT:
         begin
            r.value = {h.hi, 30'h0, (model_q.size() == depth), ne};
            r.care[31:0] = '1; // status always defined
         end
         default: r.value = {h.hi, h.lo};
      endcase
      return r;
   endfunction

   // expectation taken at the request edge
   always @(posedge rd_clk)
   begin
      if (arst_n && mi.en && !mi.we && check_rd)
      begin
         pend       = ref_read(mi.addr);
         pend_valid = 1'b1;
      end
   end

   // mi_dout is stable half a cycle after capture
   always @(negedge rd_clk)
   begin
      if (pend_valid)
      begin
         pend_valid = 1'b0;
         chk_cnt++;
         assert ((mi_dout & pend.care) === (pend.value & pend.care))
         else
         begin
            err_cnt++;
            $display("error at %0t ns: mi_dout got %h expected %h", $time, mi_dout,
                     pend.value & pend.care);
         end
      end
   end

   task automatic mesh_send(input emesh_packet_t p, input logic acc);
      @(posedge wr_clk);
      #2;
      emesh_packet = p;
      emesh_access = acc;
      ref_write(p, acc);
      @(posedge wr_clk);
      #2;
      emesh_access = 1'b0; // single-cycle strobe
   endtask

   task automatic read_reg(input logic [5:0] off, input logic chk);
      @(posedge rd_clk);
      #2;
      mi.en    = 1'b1;
      mi.we    = 1'b0;
      mi.addr  = {off, 2'b00};
      check_rd = chk;
      @(posedge rd_clk);
      #2;
      mi.en    = 1'b0; // mi_dout already captured here
   endtask

   // poll status, unchecked, until bits 1:0 match
   task automatic wait_status(input logic [1:0] want);
      do
      begin
         read_reg(`MBOX_REG_STAT, 1'b0);
      end
      while (mi_dout[1:0] !== want);
   endtask

   task automatic read_entry();
      read_reg(`MBOX_REG_LO, 1'b1);
      read_reg(`MBOX_REG_HI, 1'b1);
   endtask

   task automatic check_irq(input logic want);
      @(negedge rd_clk);
      chk_cnt++;
      assert (mailbox_irq === want)
      else
      begin
         err_cnt++;
         $display("error at %0t ns: mailbox_irq got %b expected %b", $time, mailbox_irq, want);
      end
   endtask

   task automatic end_test(input string name);
      test_cnt++;
      $display("test %0d %s done, %0d errors", test_cnt, name, err_cnt - test_err0);
      test_err0 = err_cnt;
   endtask

   initial
   begin
      logic [31:0] lo_dst;
      logic [31:0] r;
      rd_clk         = 1'b0;
      wr_clk         = 1'b0;
      arst_n         = 1'b0;
      emesh_access   = 1'b0;
      emesh_packet   = '0;
      mi             = '0;
      mailbox_irq_en = 1'b1;
      check_rd       = 1'b0;
      pend_valid     = 1'b0;
      seed           = 32'h16353fd1;
      err_cnt        = 0;
      chk_cnt        = 0;
      test_cnt       = 0;
      test_err0      = 0;
      cycles         = 0;
      lo_dst         = make_dst(link_id, `MBOX_EGROUP_MMR, `MBOX_REG_LO);
      repeat (5) @(posedge rd_clk);
      #2;
      arst_n = 1'b1;

      check_irq(1'b0);
      read_reg(`MBOX_REG_STAT, 1'b1); // empty, not full
      check_irq(1'b0);
      end_test("reset state");

      mesh_send(make_pkt(lo_dst, 1'b1), 1'b1);
      wait_status(2'b01);
      read_entry();
      read_reg(`MBOX_REG_STAT, 1'b1);
      end_test("single write");

      mesh_send(make_pkt(lo_dst, 1'b0), 1'b1); // read packet
      mesh_send(make_pkt(make_dst(link_id ^ 12'h001, `MBOX_EGROUP_MMR, `MBOX_REG_LO), 1'b1),
                1'b1);
      mesh_send(make_pkt(make_dst(link_id, `MBOX_EGROUP_MMR ^ 4'h1, `MBOX_REG_LO), 1'b1),
                1'b1);
      mesh_send(make_pkt(make_dst(link_id, `MBOX_EGROUP_MMR, `MBOX_REG_HI), 1'b1), 1'b1);
      mesh_send(make_pkt(lo_dst, 1'b1), 1'b0); // strobe low
      mesh_send(make_pkt(lo_dst, 1'b1), 1'b1); // sentinel
      wait_status(2'b01);
      read_entry();
      read_reg(`MBOX_REG_STAT, 1'b1);
      end_test("filtered writes");

      for (int i = 0; i < depth + 3; i++)
      begin
         mesh_send(make_pkt(lo_dst, 1'b1), 1'b1); // last three dropped
      end
      wait_status(2'b11);
      read_reg(`MBOX_REG_STAT, 1'b1);
      check_irq(1'b1);
      for (int i = 0; i < depth; i++)
      begin
         read_entry();
      end
      read_reg(`MBOX_REG_STAT, 1'b1);
      end_test("overflow and drain");

      @(posedge rd_clk);
      #2;
      mailbox_irq_en = 1'b0;
      mesh_send(make_pkt(lo_dst, 1'b1), 1'b1);
      wait_status(2'b01);
      repeat (4) check_irq(1'b0); // masked while holding an entry
      @(posedge rd_clk);
      #2;
      mailbox_irq_en = 1'b1;
      while (mailbox_irq !== 1'b1)
      begin
         @(negedge rd_clk);
      end
      read_entry();
      read_reg(`MBOX_REG_STAT, 1'b1);
      end_test("irq enable");

      // at most depth/2 outstanding so no write is dropped
      for (int i = 0; i < 40; i++)
      begin
         r = $random(seed);
         if (model_q.size() == 0 || (r[0] && model_q.size() < depth / 2))
         begin
            mesh_send(make_pkt(lo_dst, 1'b1), 1'b1);
         end
         else
         begin
            wait_status(2'b01);
            if (r[1])
            begin
               read_reg(`MBOX_REG_LO, 1'b1);
            end
            read_reg(`MBOX_REG_HI, 1'b1);
         end
      end
      while (model_q.size() > 0)
      begin
         wait_status(2'b01);
         read_entry();
      end
      read_reg(`MBOX_REG_STAT, 1'b1);
      end_test("random interleave");

      repeat (2) @(posedge rd_clk);
      $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", test_cnt, chk_cnt,
               err_cnt, dut_i.u_regs.asserts_i.fail_cnt);
      if (err_cnt == 0 && dut_i.u_regs.asserts_i.fail_cnt == 0)
      begin
         $display("Testbench passed");
      end
      else
      begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+logic
logic/mbox_pkg.sv
logic/emesh_decode.sv
logic/async_fifo.sv
logic/mbox_regs.sv
logic/emailbox_top.sv
sim/emailbox_asserts.sv
sim/emailbox_tb.sv

// ==== Bender.yml ====
package:
  name: emailbox

sources:
  - include_dirs:
      - logic
    files:
      - logic/mbox_pkg.sv
      - logic/emesh_decode.sv
      - logic/async_fifo.sv
      - logic/mbox_regs.sv
      - logic/emailbox_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/emailbox_asserts.sv
      - sim/emailbox_tb.sv
